/* logic/chess_pkg.sv */
package chess_pkg;

    // --------------------------------------------------
    // board types
    typedef logic [2:0]   coord_t;   // file or rank
    typedef logic [7:0]   square_t;  // [4] occupied, [3] color, [2:0] kind
    typedef logic [511:0] board_t;   // 64 squares, rank * 8 + file
    typedef logic [11:0]  disp_t;    // [9] selected, [8] cursor or selected
    typedef logic [2:0]   sound_t;
    typedef logic [2:0]   click_t;

    typedef enum logic [1:0] {
        st_play      = 2'b01,
        st_black_win = 2'b10,
        st_white_win = 2'b11
    } game_state_e;

    // --------------------------------------------------
    // piece encoding
    localparam logic color_white = 1'b0;
    localparam logic color_black = 1'b1;

    localparam logic [2:0] piece_king   = 3'd1;
    localparam logic [2:0] piece_queen  = 3'd2;
    localparam logic [2:0] piece_bishop = 3'd3;
    localparam logic [2:0] piece_knight = 3'd4;
    localparam logic [2:0] piece_rook   = 3'd5;
    localparam logic [2:0] piece_pawn   = 3'd6;

    // sound codes
    localparam sound_t snd_select   = 3'd1;
    localparam sound_t snd_deselect = 3'd2;
    localparam sound_t snd_move     = 3'd3;
    localparam sound_t snd_capture  = 3'd4;
    localparam sound_t snd_illegal  = 3'd5;
    localparam sound_t snd_gameover = 3'd7;

    localparam click_t click_none     = 3'd0;
    localparam click_t click_select   = 3'd1;
    localparam click_t click_deselect = 3'd2;
    localparam click_t click_try_move = 3'd3;
    localparam click_t click_illegal  = 3'd4;

endpackage

/* logic/click_decode.sv */
module click_decode import chess_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  logic   is_pressed,
    input  coord_t cursor_x,
    input  coord_t cursor_y,
    input  board_t board,
    input  logic   turn,
    input  logic   has_selected,
    input  coord_t sel_x,
    input  coord_t sel_y,
    output click_t click_kind
);

    logic    prev_pressed;
    logic    press_pulse;
    square_t target;
    logic    own_piece;
    logic    on_selection;

    // --------------------------------------------------
    // button edge
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prev_pressed <= 1'b0;
        end else begin
            prev_pressed <= is_pressed;
        end
    end

    assign press_pulse = is_pressed & ~prev_pressed;

    // --------------------------------------------------
    // classify the press
    assign target       = board[{cursor_y, cursor_x, 3'b000} +: 8];
    assign own_piece    = target[4] && (target[3] == turn);
    assign on_selection = has_selected && (cursor_x == sel_x) && (cursor_y == sel_y);

    always_comb begin
        click_kind = click_none;
        if (press_pulse) begin
            if (on_selection) begin
                click_kind = click_deselect;
            end else if (own_piece) begin
                click_kind = click_select;   // first pick or reselect
            end else if (has_selected) begin
                click_kind = click_try_move; // empty or enemy target
            end else begin
                click_kind = click_illegal;
            end
        end
    end

endmodule

/* logic/move_check.sv */
module move_check import chess_pkg::*; (
    input  board_t board,
    input  coord_t sel_x,
    input  coord_t sel_y,
    input  coord_t cursor_x,
    input  coord_t cursor_y,
    output logic   legal
);

    logic       sel_color;
    logic [2:0] sel_kind;
    coord_t     dx;
    coord_t     dy;
    coord_t     span;
    coord_t     step_x;
    coord_t     step_y;
    coord_t     mid_y;
    logic       target_full;
    logic       mid_full;
    logic       straight;
    logic       diagonal;
    logic       path_clear;
    logic       fwd_one;
    logic       fwd_two;
    logic       pawn_ok;
    logic       knight_ok;
    logic       king_ok;

    // --------------------------------------------------
    // geometry of the move
    assign sel_kind  = board[{sel_y, sel_x, 3'b000} +: 3];
    assign sel_color = board[{sel_y, sel_x, 3'b011}];

    assign dx = (cursor_x > sel_x) ? cursor_x - sel_x : sel_x - cursor_x;
    assign dy = (cursor_y > sel_y) ? cursor_y - sel_y : sel_y - cursor_y;

    assign span = (dx > dy) ? dx : dy;

    // unit step where 3'd7 wraps to -1
    assign step_x = (cursor_x > sel_x) ? 3'd1 : ((cursor_x < sel_x) ? 3'd7 : 3'd0);
    assign step_y = (cursor_y > sel_y) ? 3'd1 : ((cursor_y < sel_y) ? 3'd7 : 3'd0);

    assign target_full = board[{cursor_y, cursor_x, 3'b100}];

    assign straight = (dx == 3'd0) != (dy == 3'd0);
    assign diagonal = (dx == dy) && (dx != 3'd0);

    // walk the squares strictly between origin and target
    always_comb begin
        coord_t px;
        coord_t py;
        px         = sel_x;
        py         = sel_y;
        path_clear = 1'b1;
        for (int k = 1; k < 7; k++) begin
            px = px + step_x;
            py = py + step_y;
            if (k < int'(span) && board[{py, px, 3'b100}]) begin
                path_clear = 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // pawn
    always_comb begin
        if (sel_color == color_white) begin
            fwd_one = ({1'b0, cursor_y} == {1'b0, sel_y} + 4'd1);
            fwd_two = (sel_y == 3'd1) && (cursor_y == 3'd3);
            mid_y   = 3'd2;
        end else begin
            fwd_one = ({1'b0, sel_y} == {1'b0, cursor_y} + 4'd1);
            fwd_two = (sel_y == 3'd6) && (cursor_y == 3'd4);
            mid_y   = 3'd5;
        end
    end

    assign mid_full = board[{mid_y, sel_x, 3'b100}];

    assign pawn_ok = ((dx == 3'd0) && fwd_one && !target_full)
                  || ((dx == 3'd0) && fwd_two && !mid_full && !target_full)
                  || ((dx == 3'd1) && fwd_one && target_full);   // capture

    assign knight_ok = ((dx == 3'd1) && (dy == 3'd2)) || ((dx == 3'd2) && (dy == 3'd1));
    assign king_ok   = (dx <= 3'd1) && (dy <= 3'd1) && (span != 3'd0);

    // --------------------------------------------------
    // per piece rule
    always_comb begin
        case (sel_kind)
            piece_pawn:   legal = pawn_ok;
            piece_knight: legal = knight_ok;
            piece_king:   legal = king_ok;
            piece_rook:   legal = straight && path_clear;
            piece_bishop: legal = diagonal && path_clear;
            piece_queen:  legal = (straight || diagonal) && path_clear;
            default:      legal = 1'b0;
        endcase
    end

endmodule

/* logic/game_control.sv */
module game_control import chess_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  click_t       click_kind,
    input  logic         legal,
    input  coord_t       cursor_x,
    input  coord_t       cursor_y,
    output board_t       board,
    output logic         turn,
    output logic         has_selected,
    output coord_t       sel_x,
    output coord_t       sel_y,
    output game_state_e  state,
    output sound_t       sound_code,
    output logic         play_sound,
    output disp_t [63:0] board_data
);

    square_t src_sq;
    square_t dst_sq;
    logic    king_taken;

    // standard opening with white on ranks 0 and 1
    function automatic board_t opening_board();
        board_t     b;
        logic [2:0] kind;
        b = '0;
        for (int f = 0; f < 8; f++) begin
            case (f)
                0, 7:    kind = piece_rook;
                1, 6:    kind = piece_knight;
                2, 5:    kind = piece_bishop;
                3:       kind = piece_queen;
                default: kind = piece_king;
            endcase
            b[(0 * 8 + f) * 8 +: 8] = {3'b000, 1'b1, color_white, kind};
            b[(1 * 8 + f) * 8 +: 8] = {3'b000, 1'b1, color_white, piece_pawn};
            b[(6 * 8 + f) * 8 +: 8] = {3'b000, 1'b1, color_black, piece_pawn};
            b[(7 * 8 + f) * 8 +: 8] = {3'b000, 1'b1, color_black, kind};
        end
        return b;
    endfunction

    assign src_sq     = board[{sel_y, sel_x, 3'b000} +: 8];
    assign dst_sq     = board[{cursor_y, cursor_x, 3'b000} +: 8];
    assign king_taken = dst_sq[4] && (dst_sq[2:0] == piece_king);

    // --------------------------------------------------
    // board, turn, selection and game state
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            board        <= opening_board();
            turn         <= color_white;
            has_selected <= 1'b0;
            sel_x        <= '0;
            sel_y        <= '0;
            state        <= st_play;
            sound_code   <= '0;
            play_sound   <= 1'b0;
        end else begin
            play_sound <= 1'b0;  // one cycle pulse
            if (state == st_play && click_kind != click_none) begin
                play_sound <= 1'b1;
                case (click_kind)
                    click_select: begin
                        has_selected <= 1'b1;
                        sel_x        <= cursor_x;
                        sel_y        <= cursor_y;
                        sound_code   <= snd_select;
                    end
                    click_deselect: begin
                        has_selected <= 1'b0;
                        sound_code   <= snd_deselect;
                    end
                    click_try_move: begin
                        if (legal) begin
                            board[{cursor_y, cursor_x, 3'b000} +: 8] <= src_sq;
                            board[{sel_y, sel_x, 3'b000} +: 8]       <= '0;
                            turn         <= ~turn;
                            has_selected <= 1'b0;
                            if (king_taken) begin
                                sound_code <= snd_gameover;
                                state <= (turn == color_white) ? st_white_win : st_black_win;
                            end else if (dst_sq[4]) begin
                                sound_code <= snd_capture;
                            end else begin
                                sound_code <= snd_move;
                            end
                        end else begin
                            sound_code <= snd_illegal;  // rule broken or path blocked
                        end
                    end
                    default: begin
                        sound_code <= snd_illegal;
                    end
                endcase
            end
        end
    end

    // --------------------------------------------------
    // display words
    for (genvar i = 0; i < 64; i++) begin : g_disp
        logic is_cursor;
        logic is_sel;
        assign is_cursor = ({cursor_y, cursor_x} == 6'(i));
        assign is_sel    = has_selected && ({sel_y, sel_x} == 6'(i));
        assign board_data[i] = {2'b00, is_sel, is_cursor | is_sel, board[i * 8 +: 8]};
    end

endmodule

/* logic/chess_top.sv */
module chess_top import chess_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  coord_t       cursor_x,
    input  coord_t       cursor_y,
    input  logic         is_pressed,
    output game_state_e  state,
    output disp_t [63:0] board_data,
    output sound_t       sound_code,
    output logic         play_sound
);

    board_t board;
    logic   turn;
    logic   has_selected;
    coord_t sel_x;
    coord_t sel_y;
    click_t click_kind;
    logic   legal;

    click_decode u_click_decode (
        .clk          (clk),
        .rstn         (rstn),
        .is_pressed   (is_pressed),
        .cursor_x     (cursor_x),
        .cursor_y     (cursor_y),
        .board        (board),
        .turn         (turn),
        .has_selected (has_selected),
        .sel_x        (sel_x),
        .sel_y        (sel_y),
        .click_kind   (click_kind)
    );

    move_check u_move_check (
        .board    (board),
        .sel_x    (sel_x),
        .sel_y    (sel_y),
        .cursor_x (cursor_x),
        .cursor_y (cursor_y),
        .legal    (legal)
    );

    game_control u_game_control (
        .clk          (clk),
        .rstn         (rstn),
        .click_kind   (click_kind),
        .legal        (legal),
        .cursor_x     (cursor_x),
        .cursor_y     (cursor_y),
        .board        (board),
        .turn         (turn),
        .has_selected (has_selected),
        .sel_x        (sel_x),
        .sel_y        (sel_y),
        .state        (state),
        .sound_code   (sound_code),
        .play_sound   (play_sound),
        .board_data   (board_data)
    );

endmodule

/* verification/chess_checker.sv */
module chess_checker import chess_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  coord_t       cursor_x,
    input  coord_t       cursor_y,
    input  logic         is_pressed,
    input  game_state_e  state,
    input  disp_t [63:0] board_data,
    input  sound_t       sound_code,
    input  logic         play_sound,
    output logic         model_turn,
    output logic         model_selected,
    output game_state_e  model_state,
    output int           errors,
    output int           checks
);

    square_t     bd [8][8];   // [rank][file]
    logic        turn_m;
    logic        has_sel_m;
    coord_t      sel_x_m;
    coord_t      sel_y_m;
    game_state_e state_m;
    sound_t      snd_m;
    logic        play_m;
    logic        prev_pressed;
    int          err_count = 0;
    int          check_count = 0;

    assign model_turn     = turn_m;
    assign model_selected = has_sel_m;
    assign model_state    = state_m;
    assign errors         = err_count;
    assign checks         = check_count;

    // --------------------------------------------------
    // reference rules
    task automatic reset_model();
        logic [2:0] back [8];
        back = '{piece_rook, piece_knight, piece_bishop, piece_queen,
                 piece_king, piece_bishop, piece_knight, piece_rook};
        for (int r = 0; r < 8; r++) begin
            for (int f = 0; f < 8; f++) begin
                bd[r][f] = '0;
            end
        end
        for (int f = 0; f < 8; f++) begin
            bd[0][f] = {4'b0001, color_white, back[f]};
            bd[1][f] = {4'b0001, color_white, piece_pawn};
            bd[6][f] = {4'b0001, color_black, piece_pawn};
            bd[7][f] = {4'b0001, color_black, back[f]};
        end
        turn_m       = color_white;
        has_sel_m    = 1'b0;
        sel_x_m      = '0;
        sel_y_m      = '0;
        state_m      = st_play;
        snd_m        = '0;
        play_m       = 1'b0;
        prev_pressed = 1'b0;
    endtask

    function automatic int iabs(int v);
        return (v < 0) ? -v : v;
    endfunction

    function automatic int sgn(int v);
        return (v > 0) ? 1 : ((v < 0) ? -1 : 0);
    endfunction

    function automatic logic path_empty(int fx, int fy, int tx, int ty);
        int sx;
        int sy;
        int n;
        sx = sgn(tx - fx);
        sy = sgn(ty - fy);
        n  = (iabs(tx - fx) > iabs(ty - fy)) ? iabs(tx - fx) : iabs(ty - fy);
        for (int k = 1; k < n; k++) begin
            if (bd[fy + k * sy][fx + k * sx][4]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic logic rule_ok(int fx, int fy, int tx, int ty);
        square_t pc;
        int      adx;
        int      ady;
        int      dir;
        int      home;
        logic    line;
        logic    diag;
        pc   = bd[fy][fx];
        adx  = iabs(tx - fx);
        ady  = iabs(ty - fy);
        line = (adx == 0) != (ady == 0);
        diag = (adx == ady) && (adx != 0);
        dir  = (pc[3] == color_white) ? 1 : -1;
        home = (pc[3] == color_white) ? 1 : 6;
        case (pc[2:0])
            piece_pawn: begin
                if (tx == fx && ty == fy + dir) begin
                    return !bd[ty][tx][4];
                end
                if (tx == fx && fy == home && ty == fy + 2 * dir) begin
                    return !bd[ty][tx][4] && !bd[fy + dir][fx][4];
                end
                return (adx == 1) && (ty == fy + dir) && bd[ty][tx][4];
            end
            piece_knight: return (adx == 1 && ady == 2) || (adx == 2 && ady == 1);
            piece_king:   return (adx <= 1) && (ady <= 1) && (adx + ady > 0);
            piece_rook:   return line && path_empty(fx, fy, tx, ty);
            piece_bishop: return diag && path_empty(fx, fy, tx, ty);
            piece_queen:  return (line || diag) && path_empty(fx, fy, tx, ty);
            default:      return 1'b0;
        endcase
    endfunction

    task automatic apply_press(input int x, input int y);
        square_t tgt;
        logic    on_sel;
        logic    own;
        int      sx;
        int      sy;
        tgt    = bd[y][x];
        sx     = int'(sel_x_m);
        sy     = int'(sel_y_m);
        on_sel = has_sel_m && (x == sx) && (y == sy);
        own    = tgt[4] && (tgt[3] == turn_m);
        play_m = 1'b1;
        if (on_sel) begin
            has_sel_m = 1'b0;
            snd_m     = snd_deselect;
        end else if (own) begin
            has_sel_m = 1'b1;
            sel_x_m   = coord_t'(x);
            sel_y_m   = coord_t'(y);
            snd_m     = snd_select;
        end else if (!has_sel_m || !rule_ok(sx, sy, x, y)) begin
            snd_m = snd_illegal;
        end else begin
            if (tgt[4] && tgt[2:0] == piece_king) begin
                snd_m   = snd_gameover;
                state_m = (turn_m == color_white) ? st_white_win : st_black_win;
            end else if (tgt[4]) begin
                snd_m = snd_capture;
            end else begin
                snd_m = snd_move;
            end
            bd[y][x]   = bd[sy][sx];
            bd[sy][sx] = '0;
            turn_m     = ~turn_m;
            has_sel_m  = 1'b0;
        end
    endtask

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            reset_model();
        end else begin
            play_m = 1'b0;
            if (is_pressed && !prev_pressed && state_m == st_play) begin
                apply_press(int'(cursor_x), int'(cursor_y));
            end
            prev_pressed = is_pressed;
        end
    end

    // --------------------------------------------------
    // comparison at mid cycle
    task automatic compare(input string name, input int exp_v, input int act_v);
        check_count++;
        if (exp_v != act_v) begin
            err_count++;
            $display("Fail at time %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
        end
    endtask

    always @(negedge clk) begin
        logic  sel;
        logic  cur;
        disp_t exp_word;
        compare("state", int'(state_m), int'(state));
        compare("sound_code", int'(snd_m), int'(sound_code));
        compare("play_sound", int'(play_m), int'(play_sound));
        for (int i = 0; i < 64; i++) begin
            sel = has_sel_m && (sel_x_m == coord_t'(i % 8)) && (sel_y_m == coord_t'(i / 8));
            cur = (cursor_x == coord_t'(i % 8)) && (cursor_y == coord_t'(i / 8));
            exp_word = {2'b00, sel, cur | sel, bd[i / 8][i % 8]};
            compare($sformatf("board_data[%0d]", i), int'(exp_word), int'(board_data[i]));
        end
    end

endmodule

/* verification/chess_tb.sv */
module chess_tb import chess_pkg::*; ();

    localparam int n_script  = 18;
    localparam int n_random  = 400;
    localparam int n_presses = n_script + n_random;
    localparam int reset_len = 5 * 10;
    // each press takes 4 cycles and games need many presses so resets stay rare
    localparam int limit = (n_presses + 20) * 4 * 10 + (n_presses / 4 + 2) * reset_len;

    logic         clk;
    logic         rstn;
    coord_t       cursor_x;
    coord_t       cursor_y;
    logic         is_pressed;
    game_state_e  state;
    disp_t [63:0] board_data;
    sound_t       sound_code;
    logic         play_sound;
    logic         model_turn;
    logic         model_selected;
    game_state_e  model_state;
    int           errors;
    int           checks;
    int           tb_errors = 0;

    chess_top dut0 (
        .clk        (clk),
        .rstn       (rstn),
        .cursor_x   (cursor_x),
        .cursor_y   (cursor_y),
        .is_pressed (is_pressed),
        .state      (state),
        .board_data (board_data),
        .sound_code (sound_code),
        .play_sound (play_sound)
    );

    chess_checker u_checker (
        .clk            (clk),
        .rstn           (rstn),
        .cursor_x       (cursor_x),
        .cursor_y       (cursor_y),
        .is_pressed     (is_pressed),
        .state          (state),
        .board_data     (board_data),
        .sound_code     (sound_code),
        .play_sound     (play_sound),
        .model_turn     (model_turn),
        .model_selected (model_selected),
        .model_state    (model_state),
        .errors         (errors),
        .checks         (checks)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // --------------------------------------------------
    // stimulus helpers start and end 1 unit after a rising edge
    task automatic apply_reset();
        rstn = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
    endtask

    task automatic press(input int x, input int y);
        cursor_x   = coord_t'(x);
        cursor_y   = coord_t'(y);
        is_pressed = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        is_pressed = 1'b0;
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic hover(input int x, input int y);
        cursor_x = coord_t'(x);
        cursor_y = coord_t'(y);
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic pick_own(output int x, output int y);
        int   idx;
        logic found;
        found = 1'b0;
        x     = int'($urandom % 8);
        y     = int'($urandom % 8);
        for (int t = 0; t < 64; t++) begin
            idx = int'($urandom % 64);
            if (!found && board_data[idx][4] && board_data[idx][3] == model_turn) begin
                x     = idx % 8;
                y     = idx / 8;
                found = 1'b1;
            end
        end
    endtask

    task automatic random_press();
        int x;
        int y;
        if (!model_selected && ($urandom % 2) == 0) begin
            pick_own(x, y);
        end else begin
            x = int'($urandom % 8);
            y = int'($urandom % 8);
        end
        press(x, y);
    endtask

    // --------------------------------------------------
    // main sequence
    initial begin
        rstn       = 1'b0;
        cursor_x   = '0;
        cursor_y   = '0;
        is_pressed = 1'b0;
        void'($urandom(32'h4589));
        apply_reset();

        hover(2, 5);   // cursor bit only
        hover(6, 6);
        press(4, 4);   // empty square with nothing selected
        press(4, 6);   // enemy pawn
        press(4, 1);
        press(4, 1);   // deselect
        press(3, 1);
        press(4, 1);   // reselect e1
        press(4, 3);   // e1 to e3
        press(5, 6);   // black f6 to f5 opens f6 for the queen
        press(5, 5);
        press(3, 0);
        press(3, 3);   // blocked by own pawn on d1
        press(7, 4);   // d0 to h4 over e1, f2, g3
        press(0, 6);
        press(0, 5);
        press(7, 4);
        press(4, 7);   // h4 to e7 over g5 and f6 takes the king
        press(0, 5);   // no effect after game over
        press(1, 1);
        if (state != st_white_win) begin
            $display("scripted game did not end in a white win");
            tb_errors++;
        end

        apply_reset();
        for (int n = 0; n < n_random; n++) begin
            random_press();
            if (model_state != st_play) begin
                apply_reset();
            end
        end

        @(posedge clk);
        #1;
        $display("checks: %0d, errors: %0d", checks, errors + tb_errors);
        if (errors + tb_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(limit);
        $display("timeout: the run did not finish within %0d time units", limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* build.f */
logic/chess_pkg.sv
logic/click_decode.sv
logic/move_check.sv
logic/game_control.sv
logic/chess_top.sv
verification/chess_checker.sv
verification/chess_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --top-module chess_tb -f build.f --Mdir obj_dir -o chess_sim
./obj_dir/chess_sim 2>&1 | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
echo "simulation passed"
